/* include/ig_macros.svh */
`ifndef IG_MACROS_SVH
`define IG_MACROS_SVH

// ---------------------------------------------------------------------------
// image geometry
// ---------------------------------------------------------------------------

// pixels per row
`define IG_IMG_W 256

// rows per image
`define IG_IMG_H 256

// whole frame, also the size of both memories
`define IG_PIX_CNT (`IG_IMG_W * `IG_IMG_H)

// one address covers every pixel of the frame
`define IG_ADDR_W 16

`endif

/* hdl/ig_pkg.sv */
`include "ig_macros.svh"

package ig_pkg;

    // -----------------------------------------------------------------------
    // data types
    // -----------------------------------------------------------------------

    // raw 8-bit gray pixel
    typedef logic [7:0] pixel_t;

    // signed difference of two pixels, -255 .. 255
    typedef logic signed [9:0] grad_comp_t;

    // gradient memory word, gx in [19:10] and gy in [9:0]
    typedef logic [19:0] grad_word_t;

    // pixel address, same for image and gradient memory
    typedef logic [`IG_ADDR_W-1:0] addr_t;

    // window sequencing
    typedef enum logic [1:0] {
        FILL,
        RUN,
        FLUSH,
        FINISHED
    } win_state_t;

endpackage

/* hdl/ig_grad_if.sv */
`timescale 1ns/10ps

// gradient samples from the window to the writer
interface ig_grad_if ();
    import ig_pkg::*;

    logic       valid;
    logic       ready;
    // horizontal and vertical difference of one pixel
    grad_comp_t gx;
    grad_comp_t gy;

    // producer side
    modport source (output valid, output gx, output gy, input ready);

    // consumer side
    modport sink (input valid, input gx, input gy, output ready);

endinterface

/* hdl/ig_image_reader.sv */
`timescale 1ns/10ps
`include "ig_macros.svh"

module ig_image_reader (
    input  logic           clk,
    input  logic           reset,
    output logic           img_rd,
    output ig_pkg::addr_t  img_addr,
    input  ig_pkg::pixel_t img_di,
    output logic           pix_valid,
    output ig_pkg::pixel_t pix_data,
    input  logic           pix_ready
);
    import ig_pkg::*;

    addr_t      next_addr;
    logic       all_issued;
    // img_di carries read data in this cycle
    logic       rd_q;
    // two-entry skid buffer
    pixel_t     skid [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       bypass;
    logic       push;
    logic       pop;
    logic [2:0] occupancy;
    logic       issue;

    // -----------------------------------------------------------------------
    // output side
    // -----------------------------------------------------------------------

    // buffered data goes first, otherwise straight from memory
    assign pix_valid = (count != 2'd0) || rd_q;
    assign pix_data  = (count != 2'd0) ? skid[rd_ptr] : img_di;

    assign bypass = (count == 2'd0) && rd_q && pix_ready;
    assign push   = rd_q && !bypass;
    assign pop    = (count != 2'd0) && pix_ready;

    // -----------------------------------------------------------------------
    // credit
    // -----------------------------------------------------------------------

    // reads in flight plus buffered pixels, after this cycle's transfer
    assign occupancy = 3'(count) + 3'(img_rd) + 3'(rd_q) - 3'(pix_valid && pix_ready);
    assign issue     = !all_issued && (occupancy < 3'd2);

    always_ff @(posedge clk) begin
        if (reset) begin
            img_rd     <= 1'b0;
            img_addr   <= '0;
            next_addr  <= '0;
            all_issued <= 1'b0;
            rd_q       <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
        end else begin
            img_rd <= issue;
            rd_q   <= img_rd;
            if (issue) begin
                img_addr  <= next_addr;
                next_addr <= next_addr + 1'b1;
                // last address of the frame, no more reads after it
                if (next_addr == addr_t'(`IG_PIX_CNT - 1))
                    all_issued <= 1'b1;
            end
            if (push)
                wr_ptr <= !wr_ptr;
            if (pop)
                rd_ptr <= !rd_ptr;
            count <= count + 2'(push) - 2'(pop);
        end
    end

    // skid payload
    always_ff @(posedge clk) begin
        if (push)
            skid[wr_ptr] <= img_di;
    end

endmodule

/* hdl/ig_gradient_window.sv */
`timescale 1ns/10ps
`include "ig_macros.svh"

module ig_gradient_window (
    input  logic           clk,
    input  logic           reset,
    input  logic           pix_valid,
    input  ig_pkg::pixel_t pix_data,
    output logic           pix_ready,
    ig_grad_if.source      grad
);
    import ig_pkg::*;

    localparam int COL_W = $clog2(`IG_IMG_W);

    win_state_t       state;
    // win[0] is the oldest pixel and the one being output
    pixel_t           win [`IG_IMG_W];
    // column of win[0]
    logic [COL_W-1:0] out_col;
    // pixels accepted so far
    addr_t            in_cnt;
    logic             out_valid;
    grad_comp_t       out_gx;
    grad_comp_t       out_gy;
    logic             out_free;
    logic             accept;
    logic             emit;
    logic             shift;
    logic             last_col;
    grad_comp_t       gx_next;
    grad_comp_t       gy_next;

    // b minus a, both zero extended
    function automatic grad_comp_t diff(input pixel_t b, input pixel_t a);
        diff = grad_comp_t'({2'b00, b}) - grad_comp_t'({2'b00, a});
    endfunction

    // -----------------------------------------------------------------------
    // handshake
    // -----------------------------------------------------------------------

    // output register empty or draining this cycle
    assign out_free  = !out_valid || grad.ready;
    assign pix_ready = (state == FILL) || ((state == RUN) && out_free);
    assign accept    = pix_valid && pix_ready;

    // one sample per accepted pixel in RUN, free running in FLUSH
    assign emit  = ((state == RUN) && accept) || ((state == FLUSH) && out_free);
    assign shift = accept || emit;

    // -----------------------------------------------------------------------
    // differences
    // -----------------------------------------------------------------------

    assign last_col = (out_col == COL_W'(`IG_IMG_W - 1));

    // right neighbour is win[1], no right neighbour in the last column
    assign gx_next = last_col ? grad_comp_t'(0) : diff(win[1], win[0]);
    // pixel below is the incoming one, last row has none
    assign gy_next = (state == FLUSH) ? grad_comp_t'(0) : diff(pix_data, win[0]);

    assign grad.valid = out_valid;
    assign grad.gx    = out_gx;
    assign grad.gy    = out_gy;

    // -----------------------------------------------------------------------
    // control
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= FILL;
            out_col   <= '0;
            in_cnt    <= '0;
            out_valid <= 1'b0;
        end else begin
            if (accept)
                in_cnt <= in_cnt + 1'b1;
            if (emit)
                out_col <= out_col + 1'b1;

            if (emit)
                out_valid <= 1'b1;
            else if (grad.ready)
                out_valid <= 1'b0;

            case (state)
                FILL: begin
                    // one full row stored
                    if (accept && (in_cnt == addr_t'(`IG_IMG_W - 1)))
                        state <= RUN;
                end
                RUN: begin
                    // final pixel of the frame taken
                    if (accept && (in_cnt == addr_t'(`IG_PIX_CNT - 1)))
                        state <= FLUSH;
                end
                FLUSH: begin
                    // last row drained
                    if (emit && last_col)
                        state <= FINISHED;
                end
                default: begin
                    state <= FINISHED;
                end
            endcase
        end
    end

    // -----------------------------------------------------------------------
    // datapath
    // -----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (emit) begin
            out_gx <= gx_next;
            out_gy <= gy_next;
        end
        // in FLUSH the new tail entry is never read
        if (shift) begin
            for (int i = 0; i < `IG_IMG_W - 1; i++)
                win[i] <= win[i+1];
            win[`IG_IMG_W-1] <= pix_data;
        end
    end

endmodule

/* hdl/ig_grad_writer.sv */
`timescale 1ns/10ps
`include "ig_macros.svh"

module ig_grad_writer (
    input  logic               clk,
    input  logic               reset,
    ig_grad_if.sink            grad,
    output logic               grad_wr,
    output ig_pkg::addr_t      grad_addr,
    output ig_pkg::grad_word_t grad_do,
    input  logic               grad_ready,
    output logic               done
);
    import ig_pkg::*;

    // address for the next accepted sample
    addr_t next_addr;
    logic  take;
    logic  last_write;

    // -----------------------------------------------------------------------
    // handshake
    // -----------------------------------------------------------------------

    // room when empty or when the pending write completes now
    assign grad.ready = !done && (!grad_wr || grad_ready);
    assign take       = grad.valid && grad.ready;

    // final address accepted by memory
    assign last_write = grad_wr && grad_ready && (grad_addr == addr_t'(`IG_PIX_CNT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr   <= 1'b0;
            next_addr <= '0;
            done      <= 1'b0;
        end else begin
            if (take) begin
                grad_wr   <= 1'b1;
                next_addr <= next_addr + 1'b1;
            end else if (grad_ready) begin
                grad_wr <= 1'b0;
            end
            // sticky until reset
            if (last_write)
                done <= 1'b1;
        end
    end

    // write port payload, held while grad_ready is low
    always_ff @(posedge clk) begin
        if (take) begin
            grad_addr <= next_addr;
            grad_do   <= {grad.gx, grad.gy};
        end
    end

endmodule

/* hdl/ig_top.sv */
`timescale 1ns/10ps

module ig_top (
    input  logic               clk,
    input  logic               reset,
    // image memory read port
    output logic               img_rd,
    output ig_pkg::addr_t      img_addr,
    input  ig_pkg::pixel_t     img_di,
    // gradient memory write port
    output logic               grad_wr,
    output ig_pkg::addr_t      grad_addr,
    output ig_pkg::grad_word_t grad_do,
    input  logic               grad_ready,
    output logic               done
);
    import ig_pkg::*;

    // pixel stream from reader to window
    logic   pix_valid;
    pixel_t pix_data;
    logic   pix_ready;

    // gradient samples from window to writer
    ig_grad_if grad_if ();

    // -----------------------------------------------------------------------
    // pipeline
    // -----------------------------------------------------------------------

    ig_image_reader reader_i (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready)
    );

    ig_gradient_window window_i (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .pix_ready (pix_ready),
        .grad      (grad_if.source)
    );

    ig_grad_writer writer_i (
        .clk        (clk),
        .reset      (reset),
        .grad       (grad_if.sink),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready),
        .done       (done)
    );

endmodule

/* test/ig_tb.sv */
`timescale 1ns/10ps
`include "ig_macros.svh"

module ig_tb;
    import ig_pkg::*;

    localparam int W         = `IG_IMG_W;
    localparam int H         = `IG_IMG_H;
    localparam int PIX       = `IG_PIX_CNT;
    // worst case about two cycles per write, plus margin
    localparam int MAX_CYCLE = 4 * PIX + 1000;

    logic       clk;
    logic       reset      = 1'b1;
    logic       img_rd;
    addr_t      img_addr;
    pixel_t     img_di     = '0;
    logic       grad_wr;
    addr_t      grad_addr;
    grad_word_t grad_do;
    logic       grad_ready = 1'b0;
    logic       done;

    // image memory contents
    pixel_t     img_mem [PIX];
    // one bit per gradient address, set on write
    bit         written [PIX];
    logic [15:0] lfsr;
    int         cycle_cnt  = 0;
    int         rd_count   = 0;
    int         wr_count   = 0;
    logic       exp_done   = 1'b0;
    // pending write that was refused on the last edge
    logic       hold_pending = 1'b0;
    addr_t      held_addr;
    grad_word_t held_do;

    ig_top ig_top_i (
        .clk        (clk),
        .reset      (reset),
        .img_rd     (img_rd),
        .img_addr   (img_addr),
        .img_di     (img_di),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .grad_ready (grad_ready),
        .done       (done)
    );

    // ---------------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------------

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // expected word from the image, edge pixels get zero
    function automatic grad_word_t ref_grad(input addr_t a);
        int idx;
        int row;
        int col;
        int gx;
        int gy;
        idx = int'(a);
        row = idx / W;
        col = idx % W;
        gx  = 0;
        gy  = 0;
        if (col != W - 1)
            gx = int'(img_mem[idx + 1]) - int'(img_mem[idx]);
        if (row != H - 1)
            gy = int'(img_mem[idx + W]) - int'(img_mem[idx]);
        return {gx[9:0], gy[9:0]};
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_grad(input addr_t a, input grad_word_t got);
        grad_word_t exp;
        exp = ref_grad(a);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: grad_do for address %0d got %h expected %h",
                                    $time, a, got, exp));
    endtask

    task automatic check_word(input string name, input grad_word_t got, input grad_word_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
                                    $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                                    $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b",
                                    $time, name, got, exp));
    endtask

    task automatic check_done(input logic got, input logic exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0t: done got %b expected %b",
                                    $time, got, exp));
    endtask

    // ---------------------------------------------------------------------------
    // clock, memories and back-pressure
    // ---------------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // image fill, then one random grad_ready bit per cycle
    initial begin
        pixel_t pix;
        lfsr = 16'd55740;
        for (int a = 0; a < PIX; a++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr   = lfsr_next(lfsr);
                pix[b] = lfsr[0];
            end
            img_mem[a] = pix;
        end
        forever begin
            @(posedge clk);
            lfsr = lfsr_next(lfsr);
            grad_ready <= lfsr[0];
        end
    end

    // read data one cycle after img_rd
    always @(posedge clk) begin
        if (img_rd)
            img_di <= img_mem[img_addr];
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLE)
            stop_on_error($sformatf("timeout, done not seen after %0d cycles", MAX_CYCLE));
    end

    // ---------------------------------------------------------------------------
    // checking, sampled half a cycle before each rising edge
    // ---------------------------------------------------------------------------

    always @(negedge clk) begin
        if (!reset) begin
            check_done(done, exp_done);
            // refused write must stay put
            if (hold_pending) begin
                check_flag("grad_wr", grad_wr, 1'b1);
                check_addr("grad_addr", grad_addr, held_addr);
                check_word("grad_do", grad_do, held_do);
            end
            if (img_rd) begin
                if (rd_count >= PIX)
                    stop_on_error("img_rd rose again after the last image address");
                check_addr("img_addr", img_addr, addr_t'(rd_count));
                rd_count = rd_count + 1;
            end
            // write accepted on the coming edge
            if (grad_wr && grad_ready) begin
                if (wr_count >= PIX)
                    stop_on_error("gradient write after the whole frame was written");
                if (written[grad_addr])
                    stop_on_error($sformatf("address %0d written twice", grad_addr));
                check_addr("grad_addr", grad_addr, addr_t'(wr_count));
                check_grad(grad_addr, grad_do);
                written[grad_addr] = 1'b1;
                wr_count = wr_count + 1;
                if (wr_count == PIX)
                    exp_done = 1'b1;
            end
            hold_pending = grad_wr && !grad_ready;
            held_addr    = grad_addr;
            held_do      = grad_do;
        end
    end

    // ---------------------------------------------------------------------------
    // reset and end of run
    // ---------------------------------------------------------------------------

    initial begin
        int missing;
        missing = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        // first cycle out of reset
        @(negedge clk);
        check_flag("img_rd", img_rd, 1'b0);
        check_flag("grad_wr", grad_wr, 1'b0);
        check_done(done, 1'b0);

        wait (done === 1'b1);
        // nothing more gets written
        repeat (20) begin
            @(negedge clk);
            check_flag("grad_wr", grad_wr, 1'b0);
        end

        for (int a = 0; a < PIX; a++) begin
            if (!written[a])
                missing = missing + 1;
        end
        if (missing != 0)
            stop_on_error($sformatf("%0d gradient addresses were never written", missing));
        else if (rd_count != PIX)
            stop_on_error($sformatf("%0d image reads seen instead of %0d", rd_count, PIX));
        else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+include
hdl/ig_pkg.sv
hdl/ig_grad_if.sv
hdl/ig_image_reader.sv
hdl/ig_gradient_window.sv
hdl/ig_grad_writer.sv
hdl/ig_top.sv
test/ig_tb.sv

/* Makefile */
# Verilator simulation of the image gradient engine

VERILATOR  ?= verilator
FILELIST   ?= files.f
TOP        ?= ig_tb
RTL_TOP    ?= ig_top
OBJ_DIR    ?= obj_dir
BUILD_FLAGS ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
PASS_MSG   ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only when the pass message shows up on a line of its own
run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
